/* logic/pipe_macros.svh */
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// Fetch address width
`define PC_W 8

// Issue queue entries
`define QUEUE_DEPTH 4

// Front end stalls from this occupancy up
`define QUEUE_HIGH (`QUEUE_DEPTH - 2)

// Exception handler entry
`define TRAP_VEC 8'h80

`endif

/* logic/pipePkg.sv */
package pipePkg;

    typedef enum logic [2:0] {
        opNop    = 3'd0,
        opAlu    = 3'd1,
        opJump   = 3'd2,   // Resolved in D
        opBranch = 3'd3,   // Resolved in M, always taken
        opTrap   = 3'd4,   // Exception raised in M
        opFault  = 3'd5    // Exception raised in W
    } opcodeT;

    // Pipeline order, oldest stage last
    typedef enum logic [2:0] {
        stF, stF2, stI, stD, stE, stM, stM2, stW
    } stageT;

endpackage

/* logic/hazardCtrl.sv */
`timescale 1ns/1ps

module hazardCtrl import pipePkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic branchD,
    input  logic branchM,
    input  logic iWait,
    input  logic dWait,
    input  logic eWait,
    input  logic overflowI,
    input  logic excpM,
    input  logic excpW,
    output logic stallF,
    output logic stallF2,
    output logic flushF2,
    output logic stallD,
    output logic flushD,
    output logic stallI,
    output logic stallIDe,
    output logic flushI,
    output logic flushQue,
    output logic stallE,
    output logic flushE,
    output logic stallM,
    output logic flushM,
    output logic stallM2,
    output logic flushM2,
    output logic flushW
);

    logic [stM2:stF] stall;     // F through M2
    logic [stW:stF2] flush;     // F2 through W
    logic excpPend;
    logic excpPendNext;
    logic branchMPend;
    logic branchMPendNext;
    logic branchDPend;
    logic branchDPendNext;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            excpPend    <= 1'b0;
            branchMPend <= 1'b0;
            branchDPend <= 1'b0;
        end else begin
            excpPend    <= excpPendNext;
            branchMPend <= branchMPendNext;
            branchDPend <= branchDPendNext;
        end
    end

    always_comb begin
        stall = '0;
        flush = '0;
        stallIDe = 1'b0;
        flushQue = 1'b0;
        excpPendNext = excpPend;
        branchMPendNext = branchMPend;
        branchDPendNext = branchDPend;

        if (excpM || excpW) begin
            flush[stM:stF2] = '1;
            flushQue = 1'b1;
            if (excpW) begin
                flush[stW:stM2] = '1;   // Fault sits in W, kill what follows it
            end
        end else if (dWait) begin
            stall = '1;
            stallIDe = 1'b1;
            flush[stW] = 1'b1;
        end else if (branchM) begin
            flush[stM:stF2] = '1;
            flushQue = 1'b1;
            if (iWait) begin
                stall[stF] = 1'b1;      // F keeps a stale token until fetch returns
                branchMPendNext = 1'b1;
            end
        end else if (eWait) begin
            stall[stE:stF] = '1;
            stallIDe = 1'b1;
            flush[stM] = 1'b1;
        end else if (overflowI && !branchD) begin
            // Let D drain the queue, a jump in D empties it anyway
            stall[stI:stF] = '1;
        end else if (branchD) begin
            flush[stD:stF2] = '1;
            flushQue = 1'b1;
            if (iWait) begin
                stall[stF] = 1'b1;
                branchDPendNext = 1'b1;
            end
        end else if (iWait) begin
            stall[stF] = 1'b1;
            flush[stF2] = 1'b1;         // No copy of the held F token
        end

        // Fetch resumes after a redirect seen under a wait
        if (!stall[stF] && (excpPend || branchMPend || branchDPend)) begin
            flush[stF2] = 1'b1;
            flush[stD] = 1'b1;
            excpPendNext = 1'b0;
            branchMPendNext = 1'b0;
            branchDPendNext = 1'b0;
        end
        if ((excpM || excpW) && iWait) begin
            excpPendNext = 1'b1;
        end
    end

    assign stallF  = stall[stF];
    assign stallF2 = stall[stF2];
    assign stallI  = stall[stI];
    assign stallD  = stall[stD];
    assign stallE  = stall[stE];
    assign stallM  = stall[stM];
    assign stallM2 = stall[stM2];

    assign flushF2 = flush[stF2];
    assign flushI  = flush[stI];
    assign flushD  = flush[stD];
    assign flushE  = flush[stE];
    assign flushM  = flush[stM];
    assign flushM2 = flush[stM2];
    assign flushW  = flush[stW];

endmodule

/* logic/fetchStage.sv */
`timescale 1ns/1ps

`include "pipe_macros.svh"

module fetchStage import pipePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              stallF,
    input  logic              stallF2,
    input  logic              flushF2,
    input  logic              iWait,
    input  logic              branchD,
    input  logic [`PC_W-1:0]  targetD,
    input  logic              branchM,
    input  logic [`PC_W-1:0]  targetM,
    input  logic              excpM,
    input  logic              excpW,
    input  opcodeT            fetchOp,
    input  logic [`PC_W-1:0]  fetchTarget,
    output logic [`PC_W-1:0]  fetchPc,
    output logic              validF2,
    output logic [`PC_W-1:0]  pcF2,
    output opcodeT            opF2,
    output logic [`PC_W-1:0]  targetF2
);

    logic [`PC_W-1:0] pc;
    logic [`PC_W-1:0] redirPc;
    logic             redirect;
    logic             capture;
    logic             validF;
    logic [`PC_W-1:0] pcF;
    opcodeT           opF;
    logic [`PC_W-1:0] targetF;

    assign redirect = excpM || excpW || branchM || branchD;
    assign capture  = !stallF && !iWait;
    assign fetchPc  = pc;

    // Oldest event steers the pc
    always_comb begin
        if (excpM || excpW) begin
            redirPc = `TRAP_VEC;
        end else if (branchM) begin
            redirPc = targetM;
        end else begin
            redirPc = targetD;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc      <= '0;
            validF  <= 1'b0;
            validF2 <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirPc;          // Taken even while F is held
            end else if (capture) begin
                pc <= pc + 1'b1;
            end
            if (!stallF) begin
                validF <= capture && !redirect;
            end
            if (!stallF2) begin
                validF2 <= validF && !flushF2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            pcF     <= pc;
            opF     <= fetchOp;
            targetF <= fetchTarget;
        end
        if (!stallF2) begin
            pcF2     <= pcF;
            opF2     <= opF;
            targetF2 <= targetF;
        end
    end

endmodule

/* logic/issueQueue.sv */
`timescale 1ns/1ps

`include "pipe_macros.svh"

module issueQueue import pipePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              validF2,
    input  logic [`PC_W-1:0]  pcF2,
    input  opcodeT            opF2,
    input  logic [`PC_W-1:0]  targetF2,
    input  logic              stallI,
    input  logic              flushI,
    input  logic              stallIDe,
    input  logic              flushQue,
    output logic              overflowI,
    output logic              validQ,
    output logic [`PC_W-1:0]  pcQ,
    output opcodeT            opQ,
    output logic [`PC_W-1:0]  targetQ
);

    logic                             validI;
    logic [`PC_W-1:0]                 pcI;
    opcodeT                           opI;
    logic [`PC_W-1:0]                 targetI;
    logic [`PC_W-1:0]                 pcMem     [`QUEUE_DEPTH];
    opcodeT                           opMem     [`QUEUE_DEPTH];
    logic [`PC_W-1:0]                 targetMem [`QUEUE_DEPTH];
    logic [$clog2(`QUEUE_DEPTH)-1:0]  wrPtr;
    logic [$clog2(`QUEUE_DEPTH)-1:0]  rdPtr;
    logic [$clog2(`QUEUE_DEPTH):0]    count;
    logic                             push;
    logic                             pop;

    assign push = validI && !stallI && !flushQue;
    assign pop  = !stallIDe && !flushQue && (count != '0);

    assign validQ    = (count != '0);
    assign pcQ       = pcMem[rdPtr];
    assign opQ       = opMem[rdPtr];
    assign targetQ   = targetMem[rdPtr];
    assign overflowI = (count >= `QUEUE_HIGH);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validI <= 1'b0;
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
        end else begin
            if (!stallI) begin
                validI <= validF2 && !flushI;
            end
            if (flushQue) begin
                wrPtr <= '0;
                rdPtr <= '0;
                count <= '0;
            end else begin
                if (push) wrPtr <= wrPtr + 1'b1;
                if (pop) rdPtr <= rdPtr + 1'b1;
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;    // Idle or push and pop together
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stallI) begin
            pcI     <= pcF2;
            opI     <= opF2;
            targetI <= targetF2;
        end
        if (push) begin
            pcMem[wrPtr]     <= pcI;
            opMem[wrPtr]     <= opI;
            targetMem[wrPtr] <= targetI;
        end
    end

endmodule

/* logic/backEnd.sv */
`timescale 1ns/1ps

`include "pipe_macros.svh"

module backEnd import pipePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              validQ,
    input  logic [`PC_W-1:0]  pcQ,
    input  opcodeT            opQ,
    input  logic [`PC_W-1:0]  targetQ,
    input  logic              stallD,
    input  logic              flushD,
    input  logic              stallE,
    input  logic              flushE,
    input  logic              stallM,
    input  logic              flushM,
    input  logic              stallM2,
    input  logic              flushM2,
    input  logic              flushW,
    output logic              branchD,
    output logic [`PC_W-1:0]  targetD,
    output logic              branchM,
    output logic [`PC_W-1:0]  targetM,
    output logic              excpM,
    output logic              excpW,
    output logic              retireValid,
    output logic [`PC_W-1:0]  retirePc,
    output opcodeT            retireOp
);

    // Token registers D through W, indexed by stage
    logic             validS   [stD:stW];
    logic [`PC_W-1:0] pcS      [stD:stW];
    opcodeT           opS      [stD:stW];
    logic [`PC_W-1:0] targetS  [stD:stW];
    logic             validIn  [stD:stW];
    logic [`PC_W-1:0] pcIn     [stD:stW];
    opcodeT           opIn     [stD:stW];
    logic [`PC_W-1:0] targetIn [stD:stW];
    logic [stW:stD]   stallS;
    logic [stW:stD]   flushS;

    assign stallS = {1'b0, stallM2, stallM, stallE, stallD};    // W never waits
    assign flushS = {flushW, flushM2, flushM, flushE, flushD};

    always_comb begin
        validIn[stD]  = validQ;
        pcIn[stD]     = pcQ;
        opIn[stD]     = opQ;
        targetIn[stD] = targetQ;
        for (int s = stE; s <= stW; s++) begin
            validIn[s]  = validS[s-1];
            pcIn[s]     = pcS[s-1];
            opIn[s]     = opS[s-1];
            targetIn[s] = targetS[s-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int s = stD; s <= stW; s++) begin
                validS[s] <= 1'b0;
            end
        end else begin
            for (int s = stD; s <= stW; s++) begin
                if (!stallS[s]) begin
                    validS[s] <= validIn[s] && !flushS[s];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = stD; s <= stW; s++) begin
            if (!stallS[s]) begin
                pcS[s]     <= pcIn[s];
                opS[s]     <= opIn[s];
                targetS[s] <= targetIn[s];
            end
        end
    end

    assign branchD = validS[stD] && (opS[stD] == opJump);
    assign targetD = targetS[stD];
    assign branchM = validS[stM] && (opS[stM] == opBranch);
    assign targetM = targetS[stM];
    assign excpM   = validS[stM] && (opS[stM] == opTrap);
    assign excpW   = validS[stW] && (opS[stW] == opFault);

    // Trapping and faulting tokens reach W but never retire
    assign retireValid = validS[stW] && !(opS[stW] inside {opTrap, opFault});
    assign retirePc    = pcS[stW];
    assign retireOp    = opS[stW];

endmodule

/* logic/pipeTop.sv */
`timescale 1ns/1ps

`include "pipe_macros.svh"

module pipeTop import pipePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              iWait,
    input  logic              dWait,
    input  logic              eWait,
    input  opcodeT            fetchOp,
    input  logic [`PC_W-1:0]  fetchTarget,
    output logic [`PC_W-1:0]  fetchPc,
    output logic              retireValid,
    output logic [`PC_W-1:0]  retirePc,
    output opcodeT            retireOp
);

    // Hazard control
    logic stallF;
    logic stallF2;
    logic flushF2;
    logic stallD;
    logic flushD;
    logic stallI;
    logic stallIDe;
    logic flushI;
    logic flushQue;
    logic stallE;
    logic flushE;
    logic stallM;
    logic flushM;
    logic stallM2;
    logic flushM2;
    logic flushW;

    // Control events
    logic             branchD;
    logic             branchM;
    logic             excpM;
    logic             excpW;
    logic             overflowI;
    logic [`PC_W-1:0] targetD;
    logic [`PC_W-1:0] targetM;

    // Tokens between blocks
    logic             validF2;
    logic [`PC_W-1:0] pcF2;
    opcodeT           opF2;
    logic [`PC_W-1:0] targetF2;
    logic             validQ;
    logic [`PC_W-1:0] pcQ;
    opcodeT           opQ;
    logic [`PC_W-1:0] targetQ;

    hazardCtrl hazard0 (.*);

    fetchStage fetch0 (.*);

    issueQueue queue0 (.*);

    backEnd back0 (.*);

endmodule

/* sim/clkGen.sv */
`timescale 1ns/1ps

module clkGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN <= 1'b1;
    end

endmodule

/* sim/pipeChecker.sv */
`timescale 1ns/1ps

`include "pipe_macros.svh"

module pipeChecker import pipePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              retireValid,
    input  logic [`PC_W-1:0]  retirePc,
    input  opcodeT            retireOp,
    input  opcodeT            walkOp,
    input  logic [`PC_W-1:0]  walkTarget,
    output logic [`PC_W-1:0]  walkPc,
    output int                retireCount,
    output int                errorCount,
    output logic              stalled
);

    localparam int StallLimit = 300;

    int idle;

    // Architectural successor of one instruction
    function automatic logic [`PC_W-1:0] nextPc(input logic [`PC_W-1:0] pc,
                                                input opcodeT op,
                                                input logic [`PC_W-1:0] target);
        case (op)
            opJump, opBranch: return target;
            opTrap, opFault:  return `TRAP_VEC;
            default:          return pc + 1'b1;
        endcase
    endfunction

    task automatic reportMismatch(input string name, input int expected, input int actual);
        $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        errorCount++;
    endtask

    // Retire outputs are stable mid-cycle
    always @(negedge clk) begin
        if (!rstN) begin
            walkPc      <= '0;
            stalled     <= 1'b0;
            retireCount <= 0;
            errorCount  = 0;
            idle        = 0;
        end else if (retireValid) begin
            if (retireOp == opTrap || retireOp == opFault) begin
                $display("ERROR retire %0d: excepting instruction at pc %h retired",
                         retireCount, retirePc);
                errorCount++;
            end
            if (retirePc !== walkPc) begin
                reportMismatch($sformatf("retire %0d pc", retireCount), walkPc, retirePc);
            end
            if (retireOp !== walkOp) begin
                reportMismatch($sformatf("retire %0d opcode", retireCount), walkOp, retireOp);
            end
            walkPc <= nextPc(walkPc, walkOp, walkTarget);
            retireCount <= retireCount + 1;
            idle = 0;
        end else begin
            if (walkOp == opTrap || walkOp == opFault) begin
                walkPc <= `TRAP_VEC;    // Excepting instruction never shows up at retire
            end
            idle++;
            if (idle == StallLimit) begin
                $display("Retirement stalled: nothing retired for %0d cycles, next pc %h",
                         StallLimit, walkPc);
                stalled <= 1'b1;
            end
        end
    end

endmodule

/* sim/pipe_properties.sv */
`timescale 1ns/1ps

`include "pipe_macros.svh"

module pipeProperties (
    input logic                             clk,
    input logic                             rstN,
    input logic                             excpM,
    input logic                             excpW,
    input logic                             stallF,
    input logic                             stallF2,
    input logic                             stallI,
    input logic                             stallIDe,
    input logic                             stallD,
    input logic                             stallE,
    input logic                             stallM,
    input logic                             stallM2,
    input logic                             retireValid,
    input logic                             queuePush,
    input logic [$clog2(`QUEUE_DEPTH):0]    queueCount
);

    logic anyStall;

    assign anyStall = stallF || stallF2 || stallI || stallIDe || stallD || stallE
                      || stallM || stallM2;

    noStallOnExcp: assert property (@(posedge clk) disable iff (!rstN)
        (excpM || excpW) |-> !anyStall)
        else $error("Stage stall active while an exception is raised");

    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        queuePush |-> (queueCount < `QUEUE_DEPTH))
        else $error("Issue queue pushed while full");

    // Stage valids clear on the first reset edge
    retireQuietInReset: assert property (@(posedge clk) !rstN |=> !retireValid)
        else $error("retireValid high during reset");

endmodule

bind pipeTop pipeProperties props0 (
    .*,
    .queuePush(queue0.push),
    .queueCount(queue0.count)
);

/* sim/pipeTb.sv */
`timescale 1ns/1ps

`include "pipe_macros.svh"

module pipeTb import pipePkg::*; ();

    localparam int MaxCycles = 4000;

    logic             clk;
    logic             rstN;
    logic             iWait;
    logic             dWait;
    logic             eWait;
    opcodeT           fetchOp;
    logic [`PC_W-1:0] fetchTarget;
    logic [`PC_W-1:0] fetchPc;
    logic             retireValid;
    logic [`PC_W-1:0] retirePc;
    opcodeT           retireOp;
    logic [`PC_W-1:0] walkPc;
    opcodeT           walkOp;
    logic [`PC_W-1:0] walkTarget;
    int               retireCount;
    int               errorCount;
    logic             stalled;

    opcodeT           progOp     [256];
    logic [`PC_W-1:0] progTarget [256];
    logic [7:0]       vecMem     [128];
    int               expCount;
    int               seed;
    int               iRun;
    logic [31:0]      r;
    int               cycles;
    int               otherErrors;

    clkGen clk0 (.clk, .rstN);

    pipeTop dut0 (.*);

    pipeChecker check0 (.*);

    // Second lookup port for the reference walk
    assign walkOp     = progOp[walkPc];
    assign walkTarget = progTarget[walkPc];

    task automatic loadProgram();
        int i;
        for (i = 0; i < 256; i++) begin
            progOp[i]     = opNop;
            progTarget[i] = i[7:0] ^ 8'hA5;
        end
        $readmemh("sim/pipe_vectors.txt", vecMem);
        expCount = $isunknown(vecMem[0]) ? 0 : vecMem[0];
        i = 1;
        while (i + 2 < 128 && !$isunknown(vecMem[i])) begin
            progOp[vecMem[i]]     = opcodeT'(vecMem[i + 1][2:0]);
            progTarget[vecMem[i]] = vecMem[i + 2];
            i += 3;
        end
    endtask

    // Fetch answers and wait stimulus on the falling edge
    always @(negedge clk) begin
        fetchOp     = progOp[fetchPc];
        fetchTarget = progTarget[fetchPc];
        if (!rstN || retireCount < 6) begin
            iWait = 1'b0;   // Straight-line start runs without waits
            dWait = 1'b0;
            eWait = 1'b0;
        end else begin
            r = $random(seed);
            if (iRun != 0) begin
                iWait = 1'b1;
                iRun  = iRun - 1;
            end else if (r[4:0] == 5'd0) begin
                iWait = 1'b1;
                iRun  = 6 + r[8:6];     // Long fetch stall
            end else begin
                iWait = (r[10:9] == 2'd0);
            end
            dWait = (r[14:12] == 3'd0);
            eWait = (r[18:16] == 3'd0);
        end
    end

    initial begin
        iWait       = 1'b0;
        dWait       = 1'b0;
        eWait       = 1'b0;
        fetchOp     = opNop;
        fetchTarget = '0;
        seed        = 72;
        iRun        = 0;
        cycles      = 0;
        otherErrors = 0;
        loadProgram();
        if (expCount == 0) begin
            $display("Vectors file gave no expected retire count");
            otherErrors++;
        end
        while (retireCount < expCount && stalled !== 1'b1 && cycles < MaxCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (stalled === 1'b1) begin
            otherErrors++;
        end else if (retireCount < expCount) begin
            $display("Run did not finish within %0d cycles, only %0d of %0d retired",
                     MaxCycles, retireCount, expCount);
            otherErrors++;
        end
        $display("Retired %0d of %0d, %0d value errors, %0d other errors",
                 retireCount, expCount, errorCount, otherErrors);
        if (errorCount == 0 && otherErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim/pipe_vectors.txt */
// First word: expected number of retirements (hex)
// Then one instruction per line: pc opcode target (1 alu, 2 jump, 3 branch, 4 trap, 5 fault)
28
00 1 00
01 1 00
02 1 00
03 1 00
04 1 00
05 1 00
06 2 10
10 1 00
11 3 20
20 1 00
21 2 24
24 3 30
30 1 00
31 4 00
80 1 00
81 2 40
40 1 00
41 3 44
44 5 00

/* flist.f */
+incdir+logic
logic/pipePkg.sv
logic/hazardCtrl.sv
logic/fetchStage.sv
logic/issueQueue.sv
logic/backEnd.sv
logic/pipeTop.sv
sim/clkGen.sv
sim/pipeChecker.sv
sim/pipe_properties.sv
sim/pipeTb.sv

/* Bender.yml */
package:
  name: pipe_ctrl

sources:
  - include_dirs:
      - logic
    files:
      - logic/pipePkg.sv
      - logic/hazardCtrl.sv
      - logic/fetchStage.sv
      - logic/issueQueue.sv
      - logic/backEnd.sv
      - logic/pipeTop.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/clkGen.sv
      - sim/pipeChecker.sv
      - sim/pipe_properties.sv
      - sim/pipeTb.sv
